// ==== hdl/ifu_macros.svh ====
// Shared widths and SPARC opcode field values for the fetch front end
// The thread count is fixed at four because the scheduler equations are four-wide
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// Number of hardware threads, do not change
`define IFU_NUM_THREADS 4

// PC and AXI address width
`define IFU_ADDR_W 32

// Thread n comes out of reset at n times this stride
`define IFU_PC_STRIDE 32'h0000_1000

// SPARC V8 opcode fields used by the predecoder
`define IFU_OP_CALL 2'b01
`define IFU_OP_FMT2 2'b00
`define IFU_OP2_BICC 3'b010
`define IFU_COND_BA 4'b1000

`endif

// ==== hdl/ifu_pkg.sv ====
// Types shared by the fetch front end
// The instruction word is 32 bits wide, matching the AXI4-Lite data bus
`include "ifu_macros.svh"

package ifu_pkg;

   ////////////////////
   // Thread identifier
   ////////////////////

   // Wide enough to index every hardware thread
   typedef logic [$clog2(`IFU_NUM_THREADS)-1:0] tid_t;

   ////////////////////
   // Instruction views
   ////////////////////

   // Format 2 word, which carries Bicc, SETHI and the other branch classes
   typedef struct packed {
      logic [1:0]  op;
      logic        annul;
      logic [3:0]  cond;
      logic [2:0]  op2;
      logic [21:0] disp22;
   } fmt2_t;

   // Format 1 word, used only by CALL
   typedef struct packed {
      logic [1:0]  op;
      logic [29:0] disp30;
   } call_t;

   // The predecoder looks at the op field first and then picks the view
   // that matches it, so the same bits are read as either format
   typedef union packed {
      fmt2_t fmt2;
      call_t call;
   } instr_u;

endpackage

// ==== hdl/ifu_fetch_if.sv ====
// Carries one fetched word from the issue stage to the predecode stage
// A word moves on a clock edge where valid and ready are both high
`timescale 1ns/100ps
`include "ifu_macros.svh"

interface ifu_fetch_if;

   // Handshake pair
   logic valid;
   logic ready;

   // Payload, which stays steady while valid is high and ready is low
   ifu_pkg::tid_t          tid;
   logic [`IFU_ADDR_W-1:0] pc;
   ifu_pkg::instr_u        instr;

   // The issue stage fills the slot
   modport src (
      output valid, tid, pc, instr,
      input  ready
   );

   // The predecode stage drains the slot
   modport dst (
      input  valid, tid, pc, instr,
      output ready
   );

endinterface

// ==== hdl/ifu_thread_rr.sv ====
// Round-robin thread scheduler, the thread granted last gets the lowest priority
// The grant is combinational and may be zero when nobody requests
`timescale 1ns/100ps
`include "ifu_macros.svh"

module ifu_thread_rr (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [`IFU_NUM_THREADS-1:0] req_vec,
   input  logic                        advance,
   output logic [`IFU_NUM_THREADS-1:0] grant_vec
);

   // One-hot copy of the last grant that was really issued
   logic [`IFU_NUM_THREADS-1:0] park_vec;

   ////////////////////
   // Grant equations
   ////////////////////

   // A thread wins when it requests and every thread between the parked one
   // and itself in circular order is idle
   // The last term covers the case where this thread is the parked one,
   // it then wins only if nobody else asks
   for (genvar i = 0; i < `IFU_NUM_THREADS; i++) begin : g_grant
      // The three threads ahead of this one, nearest first
      localparam int P1 = (i + 3) % `IFU_NUM_THREADS;
      localparam int P2 = (i + 2) % `IFU_NUM_THREADS;
      localparam int P3 = (i + 1) % `IFU_NUM_THREADS;

      assign grant_vec[i] = req_vec[i] &
                            (park_vec[P1] |
                             park_vec[P2] & ~req_vec[P1] |
                             park_vec[P3] & ~req_vec[P2] & ~req_vec[P1] |
                             ~req_vec[P3] & ~req_vec[P2] & ~req_vec[P1]);
   end

   ////////////////////
   // Park register
   ////////////////////

   // Reset behaves as if thread 0 had just been granted, so thread 1 goes first
   // An advance with an empty grant keeps the old value, otherwise the
   // register would lose its one hot bit and fairness with it
   always_ff @(posedge clk) begin
      if (reset) begin
         park_vec <= `IFU_NUM_THREADS'(1);
      end else if (advance && (grant_vec != '0)) begin
         park_vec <= grant_vec;
      end
   end

endmodule

// ==== hdl/ifu_fetch_issue.sv ====
// Issue stage with per-thread PCs and one fetch in flight per thread
// Memory must return AXI4-Lite read data in request order, rresp is not checked
`timescale 1ns/100ps
`include "ifu_macros.svh"

module ifu_fetch_issue (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [`IFU_NUM_THREADS-1:0] thread_en,
   // AXI4-Lite read address channel
   output logic [`IFU_ADDR_W-1:0]      araddr,
   output logic [2:0]                  arprot,
   output logic                        arvalid,
   input  logic                        arready,
   // AXI4-Lite read data channel
   input  logic [31:0]                 rdata,
   input  logic [1:0]                  rresp,
   input  logic                        rvalid,
   output logic                        rready,
   // Fetched word towards predecode
   ifu_fetch_if.src                    fetch,
   // Next PC coming back from predecode
   input  logic                        wb_valid,
   input  ifu_pkg::tid_t               wb_tid,
   input  logic [`IFU_ADDR_W-1:0]      wb_pc
);

   // Per-thread state
   logic [`IFU_ADDR_W-1:0]      pc_tab [`IFU_NUM_THREADS];
   logic [`IFU_NUM_THREADS-1:0] in_flight;

   // Scheduler side
   logic [`IFU_NUM_THREADS-1:0] req_vec;
   logic [`IFU_NUM_THREADS-1:0] grant_vec;
   logic                        grant_any;
   ifu_pkg::tid_t               grant_tid;

   // Address channel bookkeeping
   logic                        ar_accept;
   logic                        ar_load;
   ifu_pkg::tid_t               ar_tid;

   // In-order tag queue, one entry per thread is enough
   ifu_pkg::tid_t               tag_q [`IFU_NUM_THREADS];
   ifu_pkg::tid_t               tag_wr;
   ifu_pkg::tid_t               tag_rd;
   logic [2:0]                  tag_count;
   logic                        r_accept;

   ////////////////////
   // Thread selection
   ////////////////////

   // A thread may ask for a new word only once its last one has been delivered
   assign req_vec = thread_en & ~in_flight;

   ifu_thread_rr ifu_thread_rr_i (
      .clk       (clk),
      .reset     (reset),
      .req_vec   (req_vec),
      .advance   (ar_accept),
      .grant_vec (grant_vec)
   );

   assign grant_any = |grant_vec;

   // Turn the one-hot grant into a thread number
   always_comb begin
      grant_tid = '0;
      for (int t = 0; t < `IFU_NUM_THREADS; t++) begin
         if (grant_vec[t]) begin
            grant_tid = ifu_pkg::tid_t'(t);
         end
      end
   end

   // PC table and in-flight bits
   // Writeback can never hit the thread being granted, that thread is idle
   always_ff @(posedge clk) begin
      if (reset) begin
         in_flight <= '0;
         for (int t = 0; t < `IFU_NUM_THREADS; t++) begin
            pc_tab[t] <= `IFU_ADDR_W'(t) * `IFU_PC_STRIDE;
         end
      end else begin
         if (ar_load && grant_any) begin
            in_flight[grant_tid] <= 1'b1;
         end
         if (wb_valid) begin
            in_flight[wb_tid] <= 1'b0;
            pc_tab[wb_tid]    <= wb_pc;
         end
      end
   end

   ////////////////////
   // Read address
   ////////////////////

   assign ar_accept = arvalid & arready;
   // The AR register takes a new grant when empty or when its word just left
   assign ar_load   = ~arvalid | arready;

   // Every fetch is an unprivileged, secure instruction access
   assign arprot = 3'b100;

   always_ff @(posedge clk) begin
      if (reset) begin
         arvalid <= 1'b0;
      end else if (ar_load) begin
         arvalid <= grant_any;
      end
   end

   always_ff @(posedge clk) begin
      if (ar_load && grant_any) begin
         araddr <= pc_tab[grant_tid];
         ar_tid <= grant_tid;
      end
   end

   ////////////////////
   // Read response
   ////////////////////

   // Responses may only be taken while a tag is waiting, so rready stays low
   // out of reset and whenever nothing is outstanding
   // The response code is dropped because errors are not handled here (rresp)
   assign rready   = (~fetch.valid | fetch.ready) & (tag_count != 3'd0);
   assign r_accept = rvalid & rready;

   // Tag queue pointers wrap on their own at four entries
   always_ff @(posedge clk) begin
      if (reset) begin
         tag_wr    <= '0;
         tag_rd    <= '0;
         tag_count <= 3'd0;
      end else begin
         if (ar_accept) begin
            tag_wr <= tag_wr + 1'b1;
         end
         if (r_accept) begin
            tag_rd <= tag_rd + 1'b1;
         end
         tag_count <= tag_count + {2'b00, ar_accept} - {2'b00, r_accept};
      end
   end

   always_ff @(posedge clk) begin
      if (ar_accept) begin
         tag_q[tag_wr] <= ar_tid;
      end
   end

   // Fetch slot, which is refilled in the same cycle it drains
   always_ff @(posedge clk) begin
      if (reset) begin
         fetch.valid <= 1'b0;
      end else if (r_accept) begin
         fetch.valid <= 1'b1;
      end else if (fetch.ready) begin
         fetch.valid <= 1'b0;
      end
   end

   // The PC of a thread in flight cannot change, so the table still holds it
   always_ff @(posedge clk) begin
      if (r_accept) begin
         fetch.tid   <= tag_q[tag_rd];
         fetch.pc    <= pc_tab[tag_q[tag_rd]];
         fetch.instr <= rdata;
      end
   end

endmodule

// ==== hdl/ifu_predecode.sv ====
// Predecode stage, one register deep, that follows CALL and BA
// Delay slots are not modeled, the target is the very next fetch of the thread
`timescale 1ns/100ps
`include "ifu_macros.svh"

module ifu_predecode (
   input  logic                   clk,
   input  logic                   reset,
   // Fetched word from the issue stage
   ifu_fetch_if.dst               fetch,
   // Instruction output handshake
   output logic                   out_valid,
   input  logic                   out_ready,
   output ifu_pkg::tid_t          out_tid,
   output logic [`IFU_ADDR_W-1:0] out_pc,
   output ifu_pkg::instr_u        out_instr,
   // Next PC back to the issue stage
   output logic                   wb_valid,
   output ifu_pkg::tid_t          wb_tid,
   output logic [`IFU_ADDR_W-1:0] wb_pc
);

   logic                   take;
   logic                   is_call;
   logic                   is_ba;
   logic [`IFU_ADDR_W-1:0] call_off;
   logic [`IFU_ADDR_W-1:0] br_off;
   logic [`IFU_ADDR_W-1:0] next_pc;

   ////////////////////
   // Output register
   ////////////////////

   // Accept a new word whenever the register is empty or leaving this cycle
   assign fetch.ready = ~out_valid | out_ready;
   assign take        = fetch.valid & fetch.ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (take) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   // Payload only moves on a take, so it holds while the consumer stalls
   always_ff @(posedge clk) begin
      if (take) begin
         out_tid   <= fetch.tid;
         out_pc    <= fetch.pc;
         out_instr <= fetch.instr;
      end
   end

   ////////////////////
   // Next PC
   ////////////////////

   // The op field decides which view of the word is meaningful
   assign is_call = (out_instr.call.op == `IFU_OP_CALL);

   // Only branch-always redirects, conditional branches fall through
   // The annul bit does not matter without delay slots
   assign is_ba = (out_instr.fmt2.op == `IFU_OP_FMT2) &&
                  (out_instr.fmt2.op2 == `IFU_OP2_BICC) &&
                  (out_instr.fmt2.cond == `IFU_COND_BA);

   // Word displacements, sign-extended to the address width and scaled to bytes
   assign call_off = `IFU_ADDR_W'(signed'(out_instr.call.disp30)) << 2;
   assign br_off   = `IFU_ADDR_W'(signed'(out_instr.fmt2.disp22)) << 2;

   always_comb begin
      if (is_call) begin
         next_pc = out_pc + call_off;
      end else if (is_ba) begin
         next_pc = out_pc + br_off;
      end else begin
         next_pc = out_pc + `IFU_ADDR_W'(4);
      end
   end

   // Writeback goes out with the output transfer itself
   // The issue stage makes the thread requestable on the next cycle
   assign wb_valid = out_valid & out_ready;
   assign wb_tid   = out_tid;
   assign wb_pc    = next_pc;

endmodule

// ==== hdl/ifu_fetch_top.sv ====
// Four-thread instruction fetch front end with an AXI4-Lite read master
// Only the read channel exists, instruction memory is assumed to be read-only
`timescale 1ns/100ps
`include "ifu_macros.svh"

module ifu_fetch_top (
   input  logic                        clk,
   input  logic                        reset,
   input  logic [`IFU_NUM_THREADS-1:0] thread_en,
   // AXI4-Lite read channel to instruction memory
   output logic [`IFU_ADDR_W-1:0]      araddr,
   output logic [2:0]                  arprot,
   output logic                        arvalid,
   input  logic                        arready,
   input  logic [31:0]                 rdata,
   input  logic [1:0]                  rresp,
   input  logic                        rvalid,
   output logic                        rready,
   // Instruction output towards the core
   output logic                        out_valid,
   input  logic                        out_ready,
   output ifu_pkg::tid_t               out_tid,
   output logic [`IFU_ADDR_W-1:0]      out_pc,
   output logic [31:0]                 out_instr
);

   // Next PC path from predecode back into the PC table
   logic                   wb_valid;
   ifu_pkg::tid_t          wb_tid;
   logic [`IFU_ADDR_W-1:0] wb_pc;

   // Slot between the two stages
   ifu_fetch_if fetch_if ();

   ifu_fetch_issue ifu_fetch_issue_i (
      .clk       (clk),
      .reset     (reset),
      .thread_en (thread_en),
      .araddr    (araddr),
      .arprot    (arprot),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .fetch     (fetch_if.src),
      .wb_valid  (wb_valid),
      .wb_tid    (wb_tid),
      .wb_pc     (wb_pc)
   );

   ifu_predecode ifu_predecode_i (
      .clk       (clk),
      .reset     (reset),
      .fetch     (fetch_if.dst),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_tid   (out_tid),
      .out_pc    (out_pc),
      .out_instr (out_instr),
      .wb_valid  (wb_valid),
      .wb_tid    (wb_tid),
      .wb_pc     (wb_pc)
   );

endmodule

// ==== bench/ifu_fetch_properties.sv ====
// Handshake and scheduler checks, bound into every ifu_fetch_top instance
// Sampled on the rising edge and ignored while reset is high
`timescale 1ns/100ps

module ifu_fetch_properties (
   input logic        clk,
   input logic        reset,
   input logic [3:0]  thread_en,
   input logic        arvalid,
   input logic        arready,
   input logic [31:0] araddr,
   input logic        out_valid,
   input logic        out_ready,
   input logic [1:0]  out_tid,
   input logic [31:0] out_pc,
   input logic [31:0] out_instr,
   input logic [3:0]  grant_vec,
   input logic [1:0]  ar_tid
);

   // Number of assertion failures seen so far
   int unsigned fail_count;

   initial fail_count = 0;

   ////////////////////
   // AXI4-Lite AR
   ////////////////////

   // A raised arvalid keeps its address until the slave takes it
   ar_hold_a: assert property (@(posedge clk) disable iff (reset)
      arvalid && !arready |=> arvalid && $stable(araddr))
   else begin
      fail_count++;
      $error("arvalid dropped or araddr moved before arready");
   end

   // The accepted fetch must belong to an enabled thread
   ar_enabled_a: assert property (@(posedge clk) disable iff (reset)
      arvalid && arready |-> thread_en[ar_tid])
   else begin
      fail_count++;
      $error("AR accepted for disabled thread %0d", ar_tid);
   end

   ////////////////////
   // Output and grant
   ////////////////////

   out_hold_a: assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_tid) &&
                                  $stable(out_pc) && $stable(out_instr))
   else begin
      fail_count++;
      $error("output handshake changed while stalled");
   end

   // At most one thread wins in any cycle
   grant_onehot_a: assert property (@(posedge clk) disable iff (reset)
      $onehot0(grant_vec))
   else begin
      fail_count++;
      $error("scheduler grant is not one-hot or zero: %b", grant_vec);
   end

endmodule

bind ifu_fetch_top ifu_fetch_properties ifu_fetch_properties_i (
   .clk       (clk),
   .reset     (reset),
   .thread_en (thread_en),
   .arvalid   (arvalid),
   .arready   (arready),
   .araddr    (araddr),
   .out_valid (out_valid),
   .out_ready (out_ready),
   .out_tid   (out_tid),
   .out_pc    (out_pc),
   .out_instr (out_instr),
   .grant_vec (ifu_fetch_issue_i.grant_vec),
   .ar_tid    (ifu_fetch_issue_i.ar_tid)
);

// ==== bench/ifu_fetch_tb.sv ====
// Directed testbench for the four-thread fetch front end with an AXI4-Lite memory model
// Memory is a sparse word table, unwritten words read as NOP, stalls come from an LFSR
`timescale 1ns/100ps
`include "ifu_macros.svh"

module ifu_fetch_tb;

   localparam int          CLK_PERIOD   = 10;
   localparam int          RESET_CYCLES = 10;
   localparam int          LOG_DEPTH    = 64;
   localparam logic [31:0] NOP_WORD     = 32'h0100_0000;
   // Instructions waited for by each test, in test order
   localparam int INSTR_TOTAL     = 4 + 32 + 8 + 48 + 20 + 64;
   localparam int INSTR_BOUND     = 40;
   localparam int WATCHDOG_CYCLES = INSTR_TOTAL * INSTR_BOUND + 6 * (RESET_CYCLES + 2);

   // DUT ports
   logic        clk;
   logic        reset;
   logic [3:0]  thread_en;
   logic [31:0] araddr;
   logic [2:0]  arprot;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;
   logic        out_valid;
   logic        out_ready;
   logic [1:0]  out_tid;
   logic [31:0] out_pc;
   logic [31:0] out_instr;

   // Controls set by the tests and applied by the driver on the falling edge
   logic        reset_ctl;
   logic [3:0]  en_ctl;
   logic        ar_manual;
   logic        ar_pulse;
   int          ar_stall;
   int          r_stall;
   int          o_stall;

   // Memory model and bookkeeping
   logic [31:0] mem [logic [31:0]];
   logic [31:0] rd_q [$];
   logic        r_fired;
   logic [31:0] lfsr_state;
   logic [31:0] ar_log [8];
   int          ar_count;
   logic [31:0] exp_pc [4];
   logic [31:0] pc_log [4][LOG_DEPTH];
   int          tid_count [4];
   int          out_count;
   int          delivered_total;
   int          errors;
   int unsigned total_fail;
   string       test_name;

   // Payload seen while the output was stalled
   logic        held_valid;
   logic [1:0]  held_tid;
   logic [31:0] held_pc;
   logic [31:0] held_instr;

   ifu_fetch_top ifu_fetch_top_i (
      .clk       (clk),
      .reset     (reset),
      .thread_en (thread_en),
      .araddr    (araddr),
      .arprot    (arprot),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_tid   (out_tid),
      .out_pc    (out_pc),
      .out_instr (out_instr)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   ////////////////////
   // Helpers
   ////////////////////

   // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit taken
   function automatic logic rand_bit();
      lfsr_state = {lfsr_state[30:0],
                    lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
      return lfsr_state[0];
   endfunction

   // True with a chance of eighths out of eight
   function automatic logic stall_roll(input int eighths);
      logic [2:0] r;
      for (int b = 0; b < 3; b++) begin
         r[b] = rand_bit();
      end
      return int'(r) < eighths;
   endfunction

   function automatic logic [31:0] mem_word(input logic [31:0] a);
      if (mem.exists(a)) begin
         return mem[a];
      end
      return NOP_WORD;
   endfunction

   // CALL and BA redirect, everything else falls through to pc+4
   function automatic logic [31:0] next_pc_ref(input logic [31:0] pc, input logic [31:0] w);
      logic [31:0] step;
      step = 32'd4;
      if (w[31:30] == `IFU_OP_CALL) begin
         step = {w[29:0], 2'b00};
      end else if (w[31:30] == `IFU_OP_FMT2 && w[24:22] == `IFU_OP2_BICC &&
                   w[28:25] == `IFU_COND_BA) begin
         step = {{8{w[21]}}, w[21:0], 2'b00};
      end
      return pc + step;
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] exp,
                                  input logic [31:0] act);
      errors++;
      $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
   endtask

   // Reference model step for one output transfer, plus the stall hold check
   task automatic check_output();
      logic [31:0] cur;
      if (held_valid && (!out_valid || out_tid !== held_tid || out_pc !== held_pc ||
                         out_instr !== held_instr)) begin
         errors++;
         $display("[ERROR] %s: output changed while stalled, pc was %h", test_name, held_pc);
      end
      held_valid = out_valid && !out_ready;
      held_tid   = out_tid;
      held_pc    = out_pc;
      held_instr = out_instr;
      if (out_valid && out_ready) begin
         if (!thread_en[out_tid]) begin
            errors++;
            $display("[ERROR] %s: instruction delivered for disabled thread %0d",
                     test_name, out_tid);
         end
         cur = exp_pc[out_tid];
         if (out_pc !== cur) begin
            report_mismatch("out_pc", cur, out_pc);
         end
         if (out_instr !== mem_word(cur)) begin
            report_mismatch("out_instr", mem_word(cur), out_instr);
         end
         exp_pc[out_tid] = next_pc_ref(cur, mem_word(cur));
         if (tid_count[out_tid] < LOG_DEPTH) begin
            pc_log[out_tid][tid_count[out_tid]] = out_pc;
         end
         tid_count[out_tid]++;
         out_count++;
         delivered_total++;
      end
   endtask

   ////////////////////
   // Driver and memory
   ////////////////////

   // Inputs change on the falling edge, then the handshakes that the next rising
   // edge will complete are recorded once the DUT logic has settled
   always @(negedge clk) begin
      reset     = reset_ctl;
      thread_en = en_ctl;
      if (reset_ctl) begin
         arready    = 1'b0;
         rvalid     = 1'b0;
         out_ready  = 1'b0;
         r_fired    = 1'b0;
         held_valid = 1'b0;
         rd_q.delete();
      end else begin
         arready  = ar_manual ? ar_pulse : ~stall_roll(ar_stall);
         ar_pulse = 1'b0;
         // rvalid and rdata hold until the response is taken
         if (!rvalid || r_fired) begin
            rvalid = (rd_q.size() != 0) && !stall_roll(r_stall);
            if (rvalid) begin
               rdata = mem_word(rd_q[0]);
            end
         end
         out_ready = ~stall_roll(o_stall);
      end
      #1;
      r_fired = rvalid && rready;
      if (!reset) begin
         if (r_fired) begin
            void'(rd_q.pop_front());
         end
         if (arvalid && arready) begin
            if (arprot[2] !== 1'b1) begin
               report_mismatch("arprot", 32'd4, 32'(arprot));
            end
            if (ar_count < 8) begin
               ar_log[ar_count] = araddr;
            end
            ar_count++;
            rd_q.push_back(araddr);
         end
         check_output();
      end
   end

   ////////////////////
   // Test sequencing
   ////////////////////

   // Lands just after the driver has sampled the current cycle
   task automatic sample_step();
      @(negedge clk);
      #2;
   endtask

   task automatic apply_reset(input logic [3:0] en, input int ar_s, input int r_s,
                              input int o_s);
      reset_ctl = 1'b1;
      en_ctl    = en;
      ar_manual = 1'b0;
      ar_stall  = ar_s;
      r_stall   = r_s;
      o_stall   = o_s;
      repeat (RESET_CYCLES) sample_step();
      for (int t = 0; t < 4; t++) begin
         exp_pc[t]    = 32'(t) * `IFU_PC_STRIDE;
         tid_count[t] = 0;
      end
      out_count = 0;
      ar_count  = 0;
      reset_ctl = 1'b0;
      sample_step();
   endtask

   task automatic wait_per_thread(input logic [3:0] mask, input int n);
      logic done;
      done = 1'b0;
      while (!done) begin
         sample_step();
         done = 1'b1;
         for (int t = 0; t < 4; t++) begin
            if (mask[t] && tid_count[t] < n) begin
               done = 1'b0;
            end
         end
      end
   endtask

   ////////////////////
   // Directed tests
   ////////////////////

   // Hold arready low and accept one AR at a time, starting after the parked thread 0
   task automatic test_reset_first_fetch();
      test_name = "reset_first_fetch";
      apply_reset(4'b0000, 0, 0, 0);
      if (arvalid !== 1'b0 || rready !== 1'b0 || out_valid !== 1'b0) begin
         errors++;
         $display("[ERROR] %s: arvalid, rready or out_valid active after reset", test_name);
      end
      ar_manual = 1'b1;
      en_ctl    = 4'b1111;
      for (int i = 0; i < 4; i++) begin
         while (!arvalid) sample_step();
         ar_pulse = 1'b1;
         sample_step();
      end
      if (ar_count < 4) begin
         errors++;
         $display("[ERROR] %s: only %0d AR transfers seen", test_name, ar_count);
      end else begin
         for (int i = 0; i < 4; i++) begin
            if (ar_log[i] !== 32'((i + 1) % 4) * `IFU_PC_STRIDE) begin
               report_mismatch("araddr", 32'((i + 1) % 4) * `IFU_PC_STRIDE, ar_log[i]);
            end
         end
      end
      ar_manual = 1'b0;
      wait_per_thread(4'b1111, 1);
   endtask

   task automatic test_sequential_stream();
      test_name = "sequential_stream";
      mem.delete();
      apply_reset(4'b1111, 0, 0, 0);
      wait_per_thread(4'b1111, 8);
      for (int t = 0; t < 4; t++) begin
         for (int k = 0; k < 8; k++) begin
            if (pc_log[t][k] !== 32'(t) * `IFU_PC_STRIDE + 32'(4 * k)) begin
               report_mismatch("stream pc", 32'(t) * `IFU_PC_STRIDE + 32'(4 * k),
                               pc_log[t][k]);
            end
         end
      end
   endtask

   // One control transfer at each reset PC, the second delivered PC shows the result
   task automatic test_control_transfer();
      logic [31:0] target [4];
      test_name = "control_transfer";
      mem.delete();
      mem[32'h0000] = {`IFU_OP_CALL, 30'd64};
      mem[32'h1000] = {`IFU_OP_CALL, 30'h3fff_fff0};
      mem[32'h2000] = {`IFU_OP_FMT2, 1'b0, `IFU_COND_BA, `IFU_OP2_BICC, 22'd32};
      mem[32'h3000] = {`IFU_OP_FMT2, 1'b0, 4'b1001, `IFU_OP2_BICC, 22'd48};
      target[0] = 32'h0000_0100;
      target[1] = 32'h0000_0fc0;
      target[2] = 32'h0000_2080;
      target[3] = 32'h0000_3004;
      apply_reset(4'b1111, 0, 0, 0);
      wait_per_thread(4'b1111, 2);
      for (int t = 0; t < 4; t++) begin
         if (pc_log[t][1] !== target[t]) begin
            report_mismatch("next pc", target[t], pc_log[t][1]);
         end
      end
   endtask

   // Stalls on every channel, order and hold are checked per transfer
   task automatic test_back_pressure();
      logic [31:0] a;
      test_name = "back_pressure";
      mem.delete();
      for (int t = 0; t < 4; t++) begin
         for (int k = 0; k < 16; k++) begin
            a      = 32'(t) * `IFU_PC_STRIDE + 32'(4 * k);
            mem[a] = {2'b10, a[31:2]};
         end
      end
      apply_reset(4'b1111, 3, 3, 3);
      wait_per_thread(4'b1111, 12);
   endtask

   task automatic test_thread_enable();
      test_name = "thread_enable";
      mem.delete();
      apply_reset(4'b0101, 1, 1, 1);
      wait_per_thread(4'b0101, 10);
      if (tid_count[1] != 0 || tid_count[3] != 0) begin
         report_mismatch("disabled thread count", 32'd0, 32'(tid_count[1] + tid_count[3]));
      end
   endtask

   task automatic test_fairness();
      test_name = "fairness";
      mem.delete();
      apply_reset(4'b1111, 0, 0, 0);
      while (out_count < 64) sample_step();
      for (int t = 0; t < 4; t++) begin
         if (tid_count[t] < 15 || tid_count[t] > 17) begin
            report_mismatch("thread share", 32'd16, 32'(tid_count[t]));
         end
      end
   endtask

   initial begin
      clk             = 1'b0;
      reset           = 1'b1;
      thread_en       = 4'b0000;
      arready         = 1'b0;
      rdata           = 32'd0;
      rresp           = 2'b00;
      rvalid          = 1'b0;
      out_ready       = 1'b0;
      reset_ctl       = 1'b1;
      en_ctl          = 4'b0000;
      ar_manual       = 1'b0;
      ar_pulse        = 1'b0;
      ar_stall        = 0;
      r_stall         = 0;
      o_stall         = 0;
      r_fired         = 1'b0;
      held_valid      = 1'b0;
      lfsr_state      = 32'hcd5088c5;
      ar_count        = 0;
      out_count       = 0;
      delivered_total = 0;
      errors          = 0;
      test_reset_first_fetch();
      test_sequential_stream();
      test_control_transfer();
      test_back_pressure();
      test_thread_enable();
      test_fairness();
      total_fail = ifu_fetch_top_i.ifu_fetch_properties_i.fail_count;
      $display("deliveries %0d, assertion failures %0d, errors %0d",
               delivered_total, total_fail, errors);
      if (errors == 0 && total_fail == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   // Bound on the whole run, scaled by the instructions each test waits for
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired after %0d cycles, the DUT stopped delivering", WATCHDOG_CYCLES);
      $display("test failed");
      $finish;
   end

endmodule

// ==== src.f ====
+incdir+hdl
hdl/ifu_pkg.sv
hdl/ifu_fetch_if.sv
hdl/ifu_thread_rr.sv
hdl/ifu_fetch_issue.sv
hdl/ifu_predecode.sv
hdl/ifu_fetch_top.sv
bench/ifu_fetch_properties.sv
bench/ifu_fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the fetch front end testbench with Verilator and run it
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module ifu_fetch_tb \
   -f src.f \
   -o ifu_fetch_sim

# Assertion errors are counted by the bench, so the run goes on past them
./obj_dir/ifu_fetch_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "test failed" sim.log; then
   echo "Simulation reported a failure, see sim.log"
   exit 1
fi

echo "Simulation finished, see sim.log"
